// File: sources.f
+incdir+bench
verilog/sha256_pkg.sv
verilog/miner_pkg.sv
verilog/sha256_core.sv
verilog/message_buffer.sv
verilog/word_counter.sv
verilog/hash_ctrl_fsm.sv
verilog/bitcoin_hash.sv
bench/bitcoin_hash_props.sv
bench/bitcoin_hash_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
    --top-module bitcoin_hash_tb -Mdir obj_dir

./obj_dir/Vbitcoin_hash_tb | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

// File: bench/sha256_ref.svh
`ifndef SHA256_REF_SVH
`define SHA256_REF_SVH

logic [31:0]  ref_k [64];
logic [255:0] ref_iv;

function automatic logic [31:0] ror(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
endfunction

// First 32 fraction bits of a root
function automatic logic [31:0] frac_bits(input real x);
    real f;
    f = (x - $floor(x)) * 4294967296.0;
    return 32'($rtoi($floor(f) - 2147483648.0)) ^ 32'h80000000;
endfunction

// IV from square roots of the first 8 primes, K from cube roots of the first 64
task automatic init_ref_constants();
    int found;
    int p;
    bit prime;
    found  = 0;
    p      = 2;
    ref_iv = '0;
    while (found < 64) begin
        prime = 1'b1;
        for (int d = 2; d * d <= p; d++)
            if (p % d == 0)
                prime = 1'b0;
        if (prime) begin
            if (found < 8)
                ref_iv = {ref_iv[223:0], frac_bits($sqrt(real'(p)))};
            ref_k[found] = frac_bits($pow(real'(p), 1.0 / 3.0));
            found++;
        end
        p++;
    end
endtask

// Words and H values are taken from the top bits down
function automatic logic [255:0] compress(input logic [255:0] hin, input logic [511:0] msg);
    logic [31:0]  w [64];
    logic [31:0]  v [8];
    logic [31:0]  s0, s1, t1, t2;
    logic [255:0] hrest;
    logic [255:0] hout;
    for (int i = 0; i < 16; i++) begin
        w[i] = msg[511:480];
        msg  = msg << 32;
    end
    for (int i = 16; i < 64; i++) begin
        s0   = ror(w[i - 15], 7) ^ ror(w[i - 15], 18) ^ (w[i - 15] >> 3);
        s1   = ror(w[i - 2], 17) ^ ror(w[i - 2], 19) ^ (w[i - 2] >> 10);
        w[i] = w[i - 16] + s0 + w[i - 7] + s1;
    end
    hrest = hin;
    for (int i = 0; i < 8; i++) begin
        v[i]  = hrest[255:224];
        hrest = hrest << 32;
    end
    for (int i = 0; i < 64; i++) begin
        t1 = v[7] + (ror(v[4], 6) ^ ror(v[4], 11) ^ ror(v[4], 25))
           + ((v[4] & v[5]) ^ (~v[4] & v[6])) + ref_k[i] + w[i];
        t2 = (ror(v[0], 2) ^ ror(v[0], 13) ^ ror(v[0], 22))
           + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
        for (int j = 7; j > 0; j--)
            v[j] = v[j - 1];
        v[4] = v[4] + t1;  // Old d plus t1
        v[0] = t1 + t2;
    end
    hrest = hin;
    hout  = '0;
    for (int i = 0; i < 8; i++) begin
        hout  = {hout[223:0], hrest[255:224] + v[i]};
        hrest = hrest << 32;
    end
    return hout;
endfunction

// H0 of the double hash for one nonce
function automatic logic [31:0] expected_h0(input logic [639:0] header, input int nonce);
    logic [255:0] mid;
    logic [255:0] first;
    logic [255:0] last;
    mid   = compress(ref_iv, header[639:128]);
    first = compress(mid, {header[127:32], 32'(nonce), 32'h80000000, 320'b0, 32'd640});
    last  = compress(ref_iv, {first, 32'h80000000, 192'b0, 32'd256});
    return last[255:224];
endfunction

`endif

// File: bench/bitcoin_hash_tb.sv
module bitcoin_hash_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS      = 64;
    localparam int TIMEOUT_CYCLES = 5000;

    logic        clk;
    logic        reset_n;
    logic        start;
    logic [15:0] message_addr;
    logic [15:0] output_addr;
    logic        done;
    logic        mem_we;
    logic [15:0] mem_addr;
    logic [31:0] mem_write_data;
    logic [31:0] mem_read_data = '0;

    logic [31:0] mem   [MEM_WORDS];
    logic [31:0] image [MEM_WORDS];  // Contents loaded before each run
    logic        load_mem;
    logic [31:0] seed;
    logic        verdict_shown;

    `include "sha256_ref.svh"

    bitcoin_hash uut (
        .clk, .reset_n, .start, .message_addr, .output_addr, .done,
        .mem_we, .mem_addr, .mem_write_data, .mem_read_data
    );

    bind bitcoin_hash bitcoin_hash_props props (
        .clk, .reset_n, .done, .mem_we, .core_start, .core_done
    );

    always #4 clk = ~clk;

    // Synchronous read and a write on the edge with mem_we
    always @(posedge clk) begin
        if (load_mem)
            mem <= image;
        else if (mem_we)
            mem[mem_addr[5:0]] <= mem_write_data;
        mem_read_data <= mem[mem_addr[5:0]];
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        verdict_shown = 1'b1;
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            abort_run("Value mismatch");
        end
    endtask

    task automatic check_quiet(input int cycles_to_watch, input string name);
        repeat (cycles_to_watch) begin
            @(negedge clk);
            check({name, " done"}, 32'd0, 32'(done));
            check({name, " mem_we"}, 32'd0, 32'(mem_we));
        end
    endtask

    task automatic run_once(input int run);
        logic [31:0]  r;
        logic [639:0] header;
        logic [31:0]  expect_h0 [16];
        logic [31:0]  want;
        logic         seen [MEM_WORDS];
        int           base, out, writes, cycles;
        r = next_rand();
        if (r[20]) begin  // Header low, outputs high
            base = int'(r[3:0]) % 5;
            out  = 40 + int'(r[11:8]) % 9;
        end else begin
            base = 40 + int'(r[3:0]) % 5;
            out  = int'(r[11:8]) % 9;
        end
        for (int a = 0; a < MEM_WORDS; a++) begin
            image[a] = next_rand();
            seen[a]  = 1'b0;
        end
        for (int i = 0; i < 20; i++)
            header = {header[607:0], image[base + i]};
        for (int n = 0; n < 16; n++)
            expect_h0[n] = expected_h0(header, n);

        @(negedge clk);
        load_mem     = 1'b1;
        start        = 1'b1;
        message_addr = 16'(base);
        output_addr  = 16'(out);
        @(negedge clk);
        load_mem = 1'b0;
        start    = 1'b0;

        writes = 0;
        cycles = 0;
        while (!done) begin
            if (mem_we) begin
                check($sformatf("run %0d write %0d address", run, writes),
                      32'(out + writes), 32'(mem_addr));
                check($sformatf("run %0d write %0d data", run, writes),
                      expect_h0[writes], mem_write_data);
                writes++;
            end else if (writes == 0 && mem_addr < 16'(MEM_WORDS)) begin
                seen[mem_addr[5:0]] = 1'b1;
            end
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                abort_run($sformatf("Timeout: done never came in run %0d", run));
        end

        check($sformatf("run %0d write count", run), 32'd16, 32'(writes));
        check($sformatf("run %0d mem_we at done", run), 32'd0, 32'(mem_we));
        for (int i = 0; i < 20; i++)
            check($sformatf("run %0d header read %0d", run, i), 32'd1, 32'(seen[base + i]));
        check_quiet(20, $sformatf("run %0d after done", run));
        for (int a = 0; a < MEM_WORDS; a++) begin
            want = (a >= out && a < out + 16) ? expect_h0[a - out] : image[a];
            check($sformatf("run %0d mem[%0d]", run, a), want, mem[a]);
        end
    endtask

    initial begin
        clk           = 1'b0;
        reset_n       = 1'b0;
        start         = 1'b0;
        message_addr  = '0;
        output_addr   = '0;
        load_mem      = 1'b0;
        seed          = 32'd20;
        verdict_shown = 1'b0;
        init_ref_constants();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        check_quiet(10, "idle after reset");
        run_once(1);
        run_once(2);
        verdict_shown = 1'b1;
        $display("TEST RESULT: PASS");
        $finish;
    end

    final begin
        if (!verdict_shown)
            $display("TEST RESULT: FAIL");
    end

endmodule

// File: bench/bitcoin_hash_props.sv
module bitcoin_hash_props (
    input logic clk,
    input logic reset_n,
    input logic done,
    input logic mem_we,
    input logic core_start,
    input logic core_done
);
    timeunit 1ns;
    timeprecision 100ps;

    logic started;  // Core has had a start since reset

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            started <= 1'b0;
        else if (core_start)
            started <= 1'b1;
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    no_write_at_done: assert property (@(posedge clk) disable iff (!reset_n)
        !(mem_we && done))
        else $error("mem_we high together with done");

    core_done_after_start: assert property (@(posedge clk) disable iff (!reset_n)
        core_done |-> started)
        else $error("core done without an earlier core start");

endmodule

// File: verilog/bitcoin_hash.sv
module bitcoin_hash (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              start,
    input  miner_pkg::addr_t  message_addr,
    input  miner_pkg::addr_t  output_addr,
    output logic              done,
    output logic              mem_we,
    output miner_pkg::addr_t  mem_addr,
    output sha256_pkg::word_t mem_write_data,
    input  sha256_pkg::word_t mem_read_data
);
    import sha256_pkg::*;
    import miner_pkg::*;

    logic       clear_word, step_word, clear_nonce, step_nonce;
    logic       load_word, save_mid, save_first;
    logic       core_start, core_done;
    logic [4:0] word_idx;
    logic       words_done, last_nonce;
    nonce_t     nonce;
    state_t     phase;
    mem_req_t   mem_req;
    block_t     block;
    digest_t    chain;
    digest_t    core_digest;

    assign mem_we         = mem_req.we;
    assign mem_addr       = mem_req.addr;
    assign mem_write_data = mem_req.data;

    hash_ctrl_fsm ctrl (
        .clk, .reset_n, .start, .message_addr, .output_addr,
        .rd_data(mem_read_data), .core_done, .core_digest,
        .word_idx, .nonce, .words_done, .last_nonce,
        .clear_word, .step_word, .clear_nonce, .step_nonce,
        .load_word, .save_mid, .save_first, .core_start,
        .phase, .mem_req, .done
    );

    word_counter counter (
        .clk, .reset_n, .clear_word, .step_word, .clear_nonce, .step_nonce,
        .word_idx, .nonce, .words_done, .last_nonce
    );

    message_buffer buffer (
        .clk, .reset_n, .load_word, .word_idx, .rd_data(mem_read_data),
        .save_mid, .save_first, .core_digest, .nonce, .phase,
        .block, .chain
    );

    sha256_core core (
        .clk, .reset_n, .start(core_start), .block, .chain,
        .digest(core_digest), .done(core_done)
    );

endmodule

// File: verilog/hash_ctrl_fsm.sv
module hash_ctrl_fsm (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                start,
    input  miner_pkg::addr_t    message_addr,
    input  miner_pkg::addr_t    output_addr,
    input  sha256_pkg::word_t   rd_data,
    input  logic                core_done,
    input  sha256_pkg::digest_t core_digest,
    input  logic [4:0]          word_idx,
    input  miner_pkg::nonce_t   nonce,
    input  logic                words_done,
    input  logic                last_nonce,
    output logic                clear_word,
    output logic                step_word,
    output logic                clear_nonce,
    output logic                step_nonce,
    output logic                load_word,
    output logic                save_mid,
    output logic                save_first,
    output logic                core_start,
    output miner_pkg::state_t   phase,
    output miner_pkg::mem_req_t mem_req,
    output logic                done
);
    import miner_pkg::*;

    state_t state;
    addr_t  msg_base;
    addr_t  out_base;

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            msg_base <= message_addr;
            out_base <= output_addr;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= IDLE;
            core_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            core_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                IDLE:
                    if (start)
                        state <= READ;
                READ:
                    if (words_done) begin  // Last word stored this edge
                        state      <= PHASE_ONE;
                        core_start <= 1'b1;
                    end
                PHASE_ONE:
                    if (core_done) begin
                        state      <= PHASE_TWO;
                        core_start <= 1'b1;
                    end
                PHASE_TWO:
                    if (core_done) begin
                        state      <= PHASE_THREE;
                        core_start <= 1'b1;
                    end
                PHASE_THREE:
                    if (core_done)
                        state <= WRITE;
                WRITE:
                    if (last_nonce) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end else begin
                        state      <= PHASE_TWO;  // Next nonce
                        core_start <= 1'b1;
                    end
                default:
                    state <= IDLE;
            endcase
        end
    end

    assign phase       = state;
    assign clear_word  = (state == IDLE) && start;
    assign clear_nonce = (state == IDLE) && start;
    assign step_word   = (state == READ) && !words_done;
    assign load_word   = (state == READ) && (word_idx != '0);
    assign save_mid    = (state == PHASE_ONE) && core_done;
    assign save_first  = (state == PHASE_TWO) && core_done;
    assign step_nonce  = (state == WRITE) && !last_nonce;

    always_comb begin
        mem_req.we = (state == WRITE);
        if (state == WRITE) begin
            mem_req.addr = out_base + addr_t'(nonce);
            mem_req.data = core_digest.h[0];  // H0 of the final digest
        end else begin
            mem_req.addr = msg_base + addr_t'(word_idx);
            mem_req.data = rd_data;  // Idle bus carries last read word
        end
    end

endmodule

// File: verilog/word_counter.sv
module word_counter (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              clear_word,
    input  logic              step_word,
    input  logic              clear_nonce,
    input  logic              step_nonce,
    output logic [4:0]        word_idx,
    output miner_pkg::nonce_t nonce,
    output logic              words_done,
    output logic              last_nonce
);
    import miner_pkg::*;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            word_idx <= '0;
            nonce    <= '0;
        end else begin
            if (clear_word)
                word_idx <= '0;
            else if (step_word)
                word_idx <= word_idx + 5'd1;

            if (clear_nonce)
                nonce <= '0;
            else if (step_nonce)
                nonce <= nonce + 4'd1;
        end
    end

    assign words_done = (word_idx == 5'(HEADER_WORDS));
    assign last_nonce = (nonce == nonce_t'(NUM_NONCES - 1));

endmodule

// File: verilog/message_buffer.sv
module message_buffer (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                load_word,
    input  logic [4:0]          word_idx,
    input  sha256_pkg::word_t   rd_data,
    input  logic                save_mid,
    input  logic                save_first,
    input  sha256_pkg::digest_t core_digest,
    input  miner_pkg::nonce_t   nonce,
    input  miner_pkg::state_t   phase,
    output sha256_pkg::block_t  block,
    output sha256_pkg::digest_t chain
);
    import sha256_pkg::*;
    import miner_pkg::*;

    word_t   hdr [HEADER_WORDS];
    digest_t mid_q;    // Phase one result
    digest_t first_q;  // Phase two result of the current nonce

    // Read data lags the counter by one
    always_ff @(posedge clk) begin
        if (load_word)
            hdr[word_idx - 5'd1] <= rd_data;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mid_q   <= '0;
            first_q <= '0;
        end else begin
            if (save_mid)
                mid_q <= core_digest;
            if (save_first)
                first_q <= core_digest;
        end
    end

    always_comb begin
        block = '0;
        chain = SHA256_IV;
        case (phase)
            PHASE_TWO: begin
                for (int i = 0; i < 3; i++)
                    block.w[i] = hdr[16 + i];
                block.w[3]  = word_t'(nonce);
                block.w[4]  = PAD_MARK;
                block.w[15] = LEN_PHASE_TWO;
                chain = mid_q;
            end
            PHASE_THREE: begin
                for (int i = 0; i < 8; i++)
                    block.w[i] = first_q.h[i];
                block.w[8]  = PAD_MARK;
                block.w[15] = LEN_PHASE_THREE;
            end
            default: begin
                for (int i = 0; i < 16; i++)
                    block.w[i] = hdr[i];
            end
        endcase
    end

endmodule

// File: verilog/sha256_core.sv
module sha256_core (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                start,
    input  sha256_pkg::block_t  block,
    input  sha256_pkg::digest_t chain,
    output sha256_pkg::digest_t digest,
    output logic                done
);
    import sha256_pkg::*;

    word_t        a, b, c, d, e, f, g, h;
    word_t [15:0] w;          // Rolling schedule with the current word in w[0]
    digest_t      chain_q;
    logic [5:0]   round;
    logic         busy;
    logic         finish;

    word_t        va, vb, vc, vd, ve, vf, vg, vh;
    word_t [15:0] vw;
    logic [5:0]   vidx;
    word_t        t1, t2;
    word_t        w_next;
    word_t [7:0]  work;

    // Round 0 runs straight off the inputs in the start cycle
    always_comb begin
        if (start) begin
            {vh, vg, vf, ve, vd, vc, vb, va} = chain.h;
            vw   = block.w;
            vidx = '0;
        end else begin
            {vh, vg, vf, ve, vd, vc, vb, va} = {h, g, f, e, d, c, b, a};
            vw   = w;
            vidx = round;
        end
        t1 = vh + big_sigma1(ve) + choose(ve, vf, vg) + round_k(vidx) + vw[0];
        t2 = big_sigma0(va) + majority(va, vb, vc);
        w_next = small_sigma1(vw[14]) + vw[9] + small_sigma0(vw[1]) + vw[0];
    end

    assign work = {h, g, f, e, d, c, b, a};

    always_ff @(posedge clk) begin
        if (start || busy) begin
            a <= t1 + t2;
            b <= va;
            c <= vb;
            d <= vc;
            e <= vd + t1;
            f <= ve;
            g <= vf;
            h <= vg;
            w <= {w_next, vw[15:1]};
        end
        if (start)
            chain_q <= chain;
        if (finish) begin
            for (int i = 0; i < 8; i++)
                digest.h[i] <= chain_q.h[i] + work[i];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy   <= 1'b0;
            round  <= '0;
            finish <= 1'b0;
            done   <= 1'b0;
        end else begin
            finish <= busy && (round == 6'(ROUNDS - 1));
            done   <= finish;
            if (start) begin
                busy  <= 1'b1;
                round <= 6'd1;
            end else if (busy) begin
                round <= round + 6'd1;
                if (round == 6'(ROUNDS - 1))
                    busy <= 1'b0;  // Add cycle follows the last round
            end
        end
    end

endmodule

// File: verilog/miner_pkg.sv
package miner_pkg;

    typedef logic [15:0] addr_t;

    typedef struct packed {
        logic               we;
        addr_t              addr;
        sha256_pkg::word_t  data;
    } mem_req_t;

    localparam int HEADER_WORDS = 20;
    localparam int NUM_NONCES   = 16;

    typedef logic [3:0] nonce_t;

    localparam sha256_pkg::word_t PAD_MARK        = 32'h80000000;
    localparam sha256_pkg::word_t LEN_PHASE_TWO   = 32'd640;  // 20 header words
    localparam sha256_pkg::word_t LEN_PHASE_THREE = 32'd256;  // One digest

    typedef enum logic [2:0] {
        IDLE,
        READ,
        PHASE_ONE,
        PHASE_TWO,
        PHASE_THREE,
        WRITE
    } state_t;

endpackage

// File: verilog/sha256_pkg.sv
package sha256_pkg;

    typedef logic [31:0] word_t;

    // w[0] is the first message word
    typedef struct packed {
        word_t [15:0] w;
    } block_t;

    // h[0] is H0
    typedef struct packed {
        word_t [7:0] h;
    } digest_t;

    localparam int ROUNDS = 64;

    // Listed H7 down to H0
    localparam digest_t SHA256_IV = '{h: {
        32'h5be0cd19, 32'h1f83d9ab, 32'h9b05688c, 32'h510e527f,
        32'ha54ff53a, 32'h3c6ef372, 32'hbb67ae85, 32'h6a09e667}};

    localparam word_t [0:63] K_TABLE = {
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2};

    function automatic word_t round_k(input logic [5:0] idx);
        return K_TABLE[idx];
    endfunction

    function automatic word_t rotr(input word_t x, input int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic word_t big_sigma0(input word_t x);
        return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
    endfunction

    function automatic word_t big_sigma1(input word_t x);
        return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
    endfunction

    function automatic word_t small_sigma0(input word_t x);
        return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
    endfunction

    function automatic word_t small_sigma1(input word_t x);
        return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
    endfunction

    function automatic word_t choose(input word_t e, input word_t f, input word_t g);
        return (e & f) ^ (~e & g);
    endfunction

    function automatic word_t majority(input word_t a, input word_t b, input word_t c);
        return (a & b) ^ (a & c) ^ (b & c);
    endfunction

endpackage
